// ==== run.sh ====
#!/usr/bin/env bash
# Build the multiply-divide unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module mdu_tb -f src.f -o mdu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mdu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0

// ==== sim/mdu_tb.sv ====
/*
    Random testbench for the multiply-divide unit
    Register model, reference arithmetic, WB order and stability checks, watchdog
*/

`timescale 1ns/1ps

module mdu_tb;

    localparam int PR_W           = 7;
    localparam int ROB_W          = 6;
    localparam int CLK_PERIOD     = 40;
    localparam int NUM_OPS        = 400;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 50;

    // Operand source kinds
    localparam int SRC_ZERO = 0;
    localparam int SRC_FWD  = 1;
    localparam int SRC_READ = 2;

    typedef struct packed {
        mdu_pkg::word_t     data;
        logic [PR_W-1:0]    pr;
        logic [ROB_W-1:0]   rob;
        logic               timed;
        int                 accept_cyc;
    } result_t;

    logic                   CLK;
    logic                   nRST;
    logic                   issue_valid;
    mdu_pkg::mdu_op_t       issue_op;
    logic                   issue_A_forward;
    logic                   issue_A_is_zero;
    logic [PR_W-1:0]        issue_A_PR;
    logic                   issue_B_forward;
    logic                   issue_B_is_zero;
    logic [PR_W-1:0]        issue_B_PR;
    logic [PR_W-1:0]        issue_dest_PR;
    logic [ROB_W-1:0]       issue_ROB_index;
    logic                   issue_ready;
    logic                   A_reg_read_ack;
    logic                   B_reg_read_ack;
    mdu_pkg::word_t         reg_read_A_data;
    mdu_pkg::word_t         reg_read_B_data;
    mdu_pkg::word_t         forward_A_data;
    mdu_pkg::word_t         forward_B_data;
    logic                   WB_valid;
    mdu_pkg::word_t         WB_data;
    logic [PR_W-1:0]        WB_PR;
    logic [ROB_W-1:0]       WB_ROB_index;
    logic                   WB_ready;

    mdu_top #(
        .LOG_PR_COUNT(PR_W),
        .LOG_ROB_ENTRIES(ROB_W)
    ) UUT (.*);

    // Model state
    mdu_pkg::word_t     regs [128];
    logic [31:0]        rng_state = 32'h4549;
    result_t            exp_q [$];
    int                 cyc = 0;
    int                 checks = 0;
    int                 value_errors = 0;
    int                 other_errors = 0;
    logic               force_ready = 1'b0;

    // Operation waiting to be issued
    logic               pend_valid = 1'b0;
    mdu_pkg::mdu_op_t   pend_op;
    int                 pend_a_src;
    int                 pend_b_src;
    logic [PR_W-1:0]    pend_a_pr;
    logic [PR_W-1:0]    pend_b_pr;
    logic [PR_W-1:0]    pend_dest;
    logic [ROB_W-1:0]   pend_rob;
    logic [1:0]         pend_a_delay;
    logic [1:0]         pend_b_delay;
    logic               pend_timed;
    mdu_pkg::word_t     pend_a_val;
    mdu_pkg::word_t     pend_b_val;
    logic [PR_W-1:0]    reuse_a_pr;
    logic [PR_W-1:0]    reuse_b_pr;

    // Operation sitting in OC
    logic               oc_busy = 1'b0;
    int                 oc_age;
    int                 oc_a_src;
    int                 oc_b_src;
    logic [1:0]         oc_a_delay;
    logic [1:0]         oc_b_delay;
    mdu_pkg::word_t     oc_a_val;
    mdu_pkg::word_t     oc_b_val;

    // WB outputs seen while the consumer stalled
    logic               held = 1'b0;
    mdu_pkg::word_t     held_data;
    logic [PR_W-1:0]    held_pr;
    logic [ROB_W-1:0]   held_rob;

    initial CLK = 1'b0;
    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // ------------------------------------------------------------------------
    // Helpers

    function automatic mdu_pkg::word_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // RV32M result for each named operation
    function automatic mdu_pkg::word_t reference_result(input mdu_pkg::mdu_op_t op,
            input mdu_pkg::word_t a, input mdu_pkg::word_t b);
        logic [63:0] a_sx;
        logic [63:0] a_zx;
        logic [63:0] b_sx;
        logic [63:0] b_zx;
        logic [63:0] prod;
        int sa;
        int sb;
        a_sx = {{32{a[31]}}, a};
        a_zx = {32'b0, a};
        b_sx = {{32{b[31]}}, b};
        b_zx = {32'b0, b};
        sa = a;
        sb = b;
        case (op)
            mdu_pkg::OP_MUL: begin
                prod = a_sx * b_sx;
                return prod[31:0];
            end
            mdu_pkg::OP_MULH: begin
                prod = a_sx * b_sx;
                return prod[63:32];
            end
            mdu_pkg::OP_MULHSU: begin
                prod = a_sx * b_zx;
                return prod[63:32];
            end
            mdu_pkg::OP_MULHU: begin
                prod = a_zx * b_zx;
                return prod[63:32];
            end
            mdu_pkg::OP_DIVU: begin
                if (b == 32'h0) return 32'hFFFFFFFF;
                return a / b;
            end
            mdu_pkg::OP_REMU: begin
                if (b == 32'h0) return a;
                return a % b;
            end
            mdu_pkg::OP_DIV: begin
                if (b == 32'h0) return 32'hFFFFFFFF;
                // Signed overflow
                if (a == 32'h80000000 && b == 32'hFFFFFFFF) return 32'h80000000;
                return sa / sb;
            end
            mdu_pkg::OP_REM: begin
                if (b == 32'h0) return a;
                if (a == 32'h80000000 && b == 32'hFFFFFFFF) return 32'h0;
                return sa % sb;
            end
        endcase
        return 32'h0;
    endfunction

    task automatic check_word(input string name, input mdu_pkg::word_t got,
            input mdu_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input logic [PR_W-1:0] got,
            input logic [PR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_rob(input string name, input logic [ROB_W-1:0] got,
            input logic [ROB_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        other_errors++;
        $display("%s", msg);
    endtask

    function automatic int pick_source(input logic [2:0] r);
        if (r == 3'd0) return SRC_ZERO;
        if (r < 3'd4) return SRC_FWD;
        return SRC_READ;
    endfunction

    function automatic mdu_pkg::word_t operand_value(input int src, input logic [PR_W-1:0] pr);
        return (src == SRC_ZERO) ? 32'h0 : regs[pr];
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus generation

    task automatic plan_timed_mul(input int k);
        mdu_pkg::word_t r;
        r = next_rand();
        pend_op = mdu_pkg::mdu_op_t'(k);
        pend_a_pr = r[6:0];
        pend_b_pr = r[13:7];
        pend_dest = r[20:14];
        // Only immediate sources, so no read wait
        pend_a_src = (r[23:21] == 3'd0) ? SRC_ZERO : SRC_FWD;
        pend_b_src = (r[26:24] == 3'd0) ? SRC_ZERO : SRC_FWD;
        pend_a_delay = 2'd0;
        pend_b_delay = 2'd0;
        pend_a_val = operand_value(pend_a_src, pend_a_pr);
        pend_b_val = operand_value(pend_b_src, pend_b_pr);
        pend_rob = k[ROB_W-1:0];
        pend_timed = 1'b1;
        pend_valid = 1'b1;
    endtask

    task automatic plan_random_op(input int idx);
        mdu_pkg::word_t r;
        mdu_pkg::word_t s;
        r = next_rand();
        s = next_rand();
        pend_op = r[2:0];
        pend_a_pr = r[9:3];
        pend_b_pr = r[16:10];
        pend_dest = r[23:17];
        pend_a_src = pick_source(r[26:24]);
        pend_b_src = pick_source(r[29:27]);
        pend_a_delay = s[1:0];
        pend_b_delay = s[3:2];

        // Corner cases and reuse pairs at fixed slots
        case (idx % 16)
            0: begin
                pend_op = {1'b1, s[5:4]};
                pend_b_pr = 7'd3;
                pend_b_src = s[6] ? SRC_ZERO : SRC_READ;
            end
            1: begin
                pend_op = s[4] ? mdu_pkg::OP_REM : mdu_pkg::OP_DIV;
                pend_a_pr = 7'd1;
                pend_b_pr = 7'd2;
                pend_a_src = s[5] ? SRC_FWD : SRC_READ;
                pend_b_src = s[6] ? SRC_FWD : SRC_READ;
            end
            8, 12: begin
                pend_op = (idx % 16 == 8) ? mdu_pkg::OP_DIV : mdu_pkg::OP_DIVU;
                pend_a_src = s[5] ? SRC_FWD : SRC_READ;
                pend_b_src = s[6] ? SRC_FWD : SRC_READ;
                reuse_a_pr = pend_a_pr;
                reuse_b_pr = pend_b_pr;
            end
            9, 13: begin
                pend_op = (idx % 16 == 9) ? mdu_pkg::OP_REM : mdu_pkg::OP_REMU;
                pend_a_src = s[5] ? SRC_FWD : SRC_READ;
                pend_b_src = s[6] ? SRC_FWD : SRC_READ;
                pend_a_pr = reuse_a_pr;
                pend_b_pr = reuse_b_pr;
            end
            default: ;
        endcase

        pend_a_val = operand_value(pend_a_src, pend_a_pr);
        pend_b_val = operand_value(pend_b_src, pend_b_pr);
        pend_rob = idx[ROB_W-1:0];
        pend_timed = 1'b0;
        pend_valid = 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // One clock cycle of driving and checking

    task automatic cycle_step();
        mdu_pkg::word_t r;
        result_t res;
        logic accepted;
        logic left_oc;

        @(negedge CLK);
        // Buses carry junk unless their data is meant to be used
        A_reg_read_ack = 1'b0;
        B_reg_read_ack = 1'b0;
        forward_A_data = next_rand();
        forward_B_data = next_rand();
        reg_read_A_data = next_rand();
        reg_read_B_data = next_rand();
        if (oc_busy) begin
            if (oc_a_src == SRC_FWD && oc_age == 0) forward_A_data = oc_a_val;
            if (oc_b_src == SRC_FWD && oc_age == 0) forward_B_data = oc_b_val;
            if (oc_a_src == SRC_READ && oc_age == int'(oc_a_delay)) begin
                A_reg_read_ack = 1'b1;
                reg_read_A_data = oc_a_val;
            end
            if (oc_b_src == SRC_READ && oc_age == int'(oc_b_delay)) begin
                B_reg_read_ack = 1'b1;
                reg_read_B_data = oc_b_val;
            end
        end

        issue_valid = pend_valid;
        issue_op = pend_op;
        issue_A_forward = (pend_a_src == SRC_FWD);
        issue_A_is_zero = (pend_a_src == SRC_ZERO);
        issue_A_PR = pend_a_pr;
        issue_B_forward = (pend_b_src == SRC_FWD);
        issue_B_is_zero = (pend_b_src == SRC_ZERO);
        issue_B_PR = pend_b_pr;
        issue_dest_PR = pend_dest;
        issue_ROB_index = pend_rob;

        r = next_rand();
        WB_ready = force_ready | (r[1:0] != 2'b00);

        #1;
        // Outputs must not move while the consumer holds them off
        if (held) begin
            if (WB_valid !== 1'b1) begin
                note_failure("WB_valid dropped while the consumer was stalling");
            end else begin
                check_word("WB_data", WB_data, held_data);
                check_tag("WB_PR", WB_PR, held_pr);
                check_rob("WB_ROB_index", WB_ROB_index, held_rob);
            end
        end
        held = WB_valid & ~WB_ready;
        held_data = WB_data;
        held_pr = WB_PR;
        held_rob = WB_ROB_index;

        if (WB_valid && WB_ready) begin
            if (exp_q.size() == 0) begin
                note_failure("A writeback arrived with no result pending");
            end else begin
                res = exp_q.pop_front();
                check_word("WB_data", WB_data, res.data);
                check_tag("WB_PR", WB_PR, res.pr);
                check_rob("WB_ROB_index", WB_ROB_index, res.rob);
                if (res.timed && cyc != res.accept_cyc + 3) begin
                    note_failure($sformatf("Multiply came back %0d cycles after issue, not 3",
                        cyc - res.accept_cyc));
                end
            end
        end

        accepted = issue_valid & issue_ready;
        left_oc = issue_ready;
        if (accepted) begin
            res.data = reference_result(pend_op, pend_a_val, pend_b_val);
            res.pr = pend_dest;
            res.rob = pend_rob;
            res.timed = pend_timed;
            res.accept_cyc = cyc;
            exp_q.push_back(res);
        end

        @(posedge CLK);
        cyc++;
        if (left_oc) oc_busy = 1'b0;
        else if (oc_busy) oc_age++;
        if (accepted) begin
            oc_busy = 1'b1;
            oc_age = 0;
            oc_a_src = pend_a_src;
            oc_b_src = pend_b_src;
            oc_a_delay = pend_a_delay;
            oc_b_delay = pend_b_delay;
            oc_a_val = pend_a_val;
            oc_b_val = pend_b_val;
            pend_valid = 1'b0;
        end
    endtask

    task automatic issue_pending();
        while (pend_valid) cycle_step();
    endtask

    task automatic drain_results();
        while (exp_q.size() != 0) cycle_step();
    endtask

    // ------------------------------------------------------------------------
    // Main sequence

    initial begin
        nRST = 1'b0;
        issue_valid = 1'b0;
        issue_op = mdu_pkg::OP_MUL;
        issue_A_forward = 1'b0;
        issue_A_is_zero = 1'b0;
        issue_A_PR = '0;
        issue_B_forward = 1'b0;
        issue_B_is_zero = 1'b0;
        issue_B_PR = '0;
        issue_dest_PR = '0;
        issue_ROB_index = '0;
        A_reg_read_ack = 1'b0;
        B_reg_read_ack = 1'b0;
        reg_read_A_data = '0;
        reg_read_B_data = '0;
        forward_A_data = '0;
        forward_B_data = '0;
        WB_ready = 1'b0;

        for (int i = 0; i < 128; i++) begin
            regs[i] = next_rand();
        end
        // Fixed corner registers
        regs[1] = 32'h80000000;
        regs[2] = 32'hFFFFFFFF;
        regs[3] = 32'h0;

        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        #1;
        if (WB_valid !== 1'b0) note_failure("WB_valid is high right after reset");
        if (issue_ready !== 1'b1) note_failure("issue_ready is low right after reset");

        // Multiply latency with nothing in the way
        force_ready = 1'b1;
        for (int k = 0; k < 4; k++) begin
            plan_timed_mul(k);
            issue_pending();
            drain_results();
        end
        force_ready = 1'b0;

        for (int idx = 4; idx < NUM_OPS; idx++) begin
            plan_random_op(idx);
            issue_pending();
        end
        drain_results();
        // Idle cycles to catch a stray extra writeback
        repeat (8) cycle_step();

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
            checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Run timed out with %0d results still pending", exp_q.size());
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== source/div32_nonrestoring.sv ====
/*
    Iterative 32-bit non-restoring divider
    Signed and unsigned modes with RISC-V divide-by-zero and overflow results
*/

`timescale 1ns/1ps

module div32_nonrestoring (
    input logic     CLK,
    input logic     nRST,
    mdu_div_if.div  div
);

    mdu_pkg::div_state_e    state;
    logic [5:0]             count;

    // Partial remainder is 33-bit two's complement
    logic [32:0]            p;
    mdu_pkg::word_t         q;
    mdu_pkg::word_t         d;
    logic                   q_neg;
    logic                   r_neg;

    mdu_pkg::word_t         a_mag;
    mdu_pkg::word_t         b_mag;
    logic [32:0]            p_shift;
    logic [32:0]            p_step;
    logic [32:0]            p_fix;

    // ------------------------------------------------------------------------
    // Datapath

    assign a_mag = (div.is_signed & div.dividend[31]) ? -div.dividend : div.dividend;
    assign b_mag = (div.is_signed & div.divisor[31]) ? -div.divisor : div.divisor;

    // Shift in the next dividend bit, then add or subtract by the sign
    assign p_shift = {p[31:0], q[31]};
    assign p_step = p[32] ? p_shift + {1'b0, d} : p_shift - {1'b0, d};
    assign p_fix = p[32] ? p + {1'b0, d} : p;

    always_ff @(posedge CLK) begin
        if (~div.clear && state == mdu_pkg::DIV_IDLE) begin
            p <= '0;
            q <= a_mag;
            d <= b_mag;
            // Zero divisor keeps the all-ones quotient unsigned
            q_neg <= div.is_signed & (div.dividend[31] ^ div.divisor[31]) & (|div.divisor);
            r_neg <= div.is_signed & div.dividend[31];
        end else if (~div.clear && state == mdu_pkg::DIV_RUN) begin
            if (count != 6'd32) begin
                p <= p_step;
                q <= {q[30:0], ~p_step[32]};
            end else begin
                // Final fix-up and sign restore
                // Most negative / -1 wraps back to the most negative number
                p <= r_neg ? -p_fix : p_fix;
                q <= q_neg ? -q : q;
            end
        end
    end

    // ------------------------------------------------------------------------
    // FSM

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            state <= mdu_pkg::DIV_IDLE;
            count <= '0;
        end else if (div.clear) begin
            state <= mdu_pkg::DIV_IDLE;
            count <= '0;
        end else begin
            case (state)
                mdu_pkg::DIV_IDLE: begin
                    state <= mdu_pkg::DIV_RUN;
                    count <= '0;
                end
                mdu_pkg::DIV_RUN: begin
                    if (count == 6'd32) begin
                        state <= mdu_pkg::DIV_DONE;
                    end
                    count <= count + 6'd1;
                end
                mdu_pkg::DIV_DONE: begin
                    if (~div.hold) begin
                        state <= mdu_pkg::DIV_IDLE;
                    end
                end
                default: state <= mdu_pkg::DIV_IDLE;
            endcase
        end
    end

    assign div.done = (state == mdu_pkg::DIV_DONE);
    assign div.quotient = q;
    assign div.remainder = p[31:0];

endmodule

// ==== source/mdu_div_if.sv ====
/*
    Pipeline to divider connection
*/

`timescale 1ns/1ps

interface mdu_div_if;

    // Control from the WB stage
    logic               clear;
    logic               is_signed;
    logic               hold;

    // Operands of the divide sitting in WB
    mdu_pkg::word_t     dividend;
    mdu_pkg::word_t     divisor;

    // Results
    logic               done;
    mdu_pkg::word_t     quotient;
    mdu_pkg::word_t     remainder;

    modport pipe (output clear, is_signed, hold, dividend, divisor,
                  input done, quotient, remainder);
    modport div  (input clear, is_signed, hold, dividend, divisor,
                  output done, quotient, remainder);

endinterface

// ==== source/mdu_mul_if.sv ====
/*
    Pipeline to multiplier connection
*/

`timescale 1ns/1ps

interface mdu_mul_if;

    // 33-bit operands, already sign or zero extended
    logic [32:0]        a33;
    logic [32:0]        b33;

    // Stage enables follow the pipeline stalls
    logic               ex_en;
    logic               wb_en;

    mdu_pkg::dword_t    product;

    modport pipe (output a33, b33, ex_en, wb_en, input product);
    modport mul  (input a33, b33, ex_en, wb_en, output product);

endinterface

// ==== source/mdu_multiplier.sv ====
/*
    Two-stage 33x33 signed multiplier with independent stage enables
*/

`timescale 1ns/1ps

module mdu_multiplier (
    input logic     CLK,
    input logic     nRST,
    mdu_mul_if.mul  mul
);

    logic signed [65:0] full_product;
    mdu_pkg::dword_t    stage1_product;

    // Upper two bits never matter for 32-bit sources
    assign full_product = $signed(mul.a33) * $signed(mul.b33);

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            stage1_product <= '0;
            mul.product <= '0;
        end else begin
            // Stage 1 tracks the EX stage
            if (mul.ex_en) begin
                stage1_product <= full_product[63:0];
            end
            // Stage 2 tracks the WB stage
            if (mul.wb_en) begin
                mul.product <= stage1_product;
            end
        end
    end

endmodule

// ==== source/mdu_pipeline.sv ====
/*
    OC/EX/WB control of the multiply-divide unit
    Operand collection, stall chain, divide reuse and result selection
*/

`timescale 1ns/1ps

module mdu_pipeline #(
    parameter int LOG_PR_COUNT    = 7,
    parameter int LOG_ROB_ENTRIES = 6
) (
    input  logic                        CLK,
    input  logic                        nRST,

    input  logic                        issue_valid,
    input  mdu_pkg::mdu_op_t            issue_op,
    input  logic                        issue_A_forward,
    input  logic                        issue_A_is_zero,
    input  logic [LOG_PR_COUNT-1:0]     issue_A_PR,
    input  logic                        issue_B_forward,
    input  logic                        issue_B_is_zero,
    input  logic [LOG_PR_COUNT-1:0]     issue_B_PR,
    input  logic [LOG_PR_COUNT-1:0]     issue_dest_PR,
    input  logic [LOG_ROB_ENTRIES-1:0]  issue_ROB_index,
    output logic                        issue_ready,

    input  logic                        A_reg_read_ack,
    input  logic                        B_reg_read_ack,
    input  mdu_pkg::word_t              reg_read_A_data,
    input  mdu_pkg::word_t              reg_read_B_data,
    input  mdu_pkg::word_t              forward_A_data,
    input  mdu_pkg::word_t              forward_B_data,

    output logic                        WB_valid,
    output mdu_pkg::word_t              WB_data,
    output logic [LOG_PR_COUNT-1:0]     WB_PR,
    output logic [LOG_ROB_ENTRIES-1:0]  WB_ROB_index,
    input  logic                        WB_ready,

    mdu_mul_if.pipe                     mul,
    mdu_div_if.pipe                     div
);

    logic stall_wb;
    logic stall_ex;
    logic stall_oc;

    // OC stage
    logic                           valid_oc;
    mdu_pkg::mdu_op_t               op_oc;
    logic                           a_saved_oc;
    logic                           a_forward_oc;
    logic                           a_zero_oc;
    logic                           b_saved_oc;
    logic                           b_forward_oc;
    logic                           b_zero_oc;
    logic [LOG_PR_COUNT-1:0]        a_pr_oc;
    logic [LOG_PR_COUNT-1:0]        b_pr_oc;
    logic [LOG_PR_COUNT-1:0]        dest_pr_oc;
    logic [LOG_ROB_ENTRIES-1:0]     rob_oc;
    mdu_pkg::word_t                 a_saved_data_oc;
    mdu_pkg::word_t                 b_saved_data_oc;
    mdu_pkg::word_t                 a_data_oc;
    mdu_pkg::word_t                 b_data_oc;
    logic                           launch_oc;

    // EX stage
    logic                           valid_ex;
    mdu_pkg::mdu_op_t               op_ex;
    logic [LOG_PR_COUNT-1:0]        a_pr_ex;
    logic [LOG_PR_COUNT-1:0]        b_pr_ex;
    logic [LOG_PR_COUNT-1:0]        dest_pr_ex;
    logic [LOG_ROB_ENTRIES-1:0]     rob_ex;
    mdu_pkg::word_t                 a_data_ex;
    mdu_pkg::word_t                 b_data_ex;
    logic                           hit_ex;
    mdu_pkg::word_t                 hit_data_ex;

    // WB stage
    logic                           valid_wb;
    mdu_pkg::mdu_op_t               op_wb;
    logic [LOG_PR_COUNT-1:0]        a_pr_wb;
    logic [LOG_PR_COUNT-1:0]        b_pr_wb;
    logic [LOG_PR_COUNT-1:0]        dest_pr_wb;
    logic [LOG_ROB_ENTRIES-1:0]     rob_wb;
    mdu_pkg::word_t                 a_data_wb;
    mdu_pkg::word_t                 b_data_wb;
    logic                           hit_wb;
    mdu_pkg::word_t                 hit_data_wb;

    // ------------------------------------------------------------------------
    // Stall chain

    // WB waits on the consumer, or on the divider unless the result is reused
    assign stall_wb = valid_wb & (~WB_ready | (op_wb[2] & ~(div.done | hit_wb)));
    assign stall_ex = stall_wb & valid_ex;
    assign stall_oc = stall_ex & valid_oc;

    // ------------------------------------------------------------------------
    // OC stage

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_oc <= 1'b0;
            a_saved_oc <= 1'b0;
            a_forward_oc <= 1'b0;
            b_saved_oc <= 1'b0;
            b_forward_oc <= 1'b0;
        end else if (~issue_ready) begin
            // Keep whatever showed up while waiting
            a_saved_oc <= a_saved_oc | a_forward_oc | A_reg_read_ack;
            a_forward_oc <= 1'b0;
            b_saved_oc <= b_saved_oc | b_forward_oc | B_reg_read_ack;
            b_forward_oc <= 1'b0;
        end else begin
            valid_oc <= issue_valid;
            a_saved_oc <= 1'b0;
            a_forward_oc <= issue_A_forward;
            b_saved_oc <= 1'b0;
            b_forward_oc <= issue_B_forward;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            op_oc <= issue_op;
            a_zero_oc <= issue_A_is_zero;
            b_zero_oc <= issue_B_is_zero;
            a_pr_oc <= issue_A_PR;
            b_pr_oc <= issue_B_PR;
            dest_pr_oc <= issue_dest_PR;
            rob_oc <= issue_ROB_index;
        end
        a_saved_data_oc <= a_data_oc;
        b_saved_data_oc <= b_data_oc;
    end

    // Operand select: zero, saved, forward, then read data
    always_comb begin
        if (a_zero_oc) a_data_oc = '0;
        else if (a_saved_oc) a_data_oc = a_saved_data_oc;
        else if (a_forward_oc) a_data_oc = forward_A_data;
        else a_data_oc = reg_read_A_data;

        if (b_zero_oc) b_data_oc = '0;
        else if (b_saved_oc) b_data_oc = b_saved_data_oc;
        else if (b_forward_oc) b_data_oc = forward_B_data;
        else b_data_oc = reg_read_B_data;
    end

    assign launch_oc = ~stall_oc
        & (a_zero_oc | a_saved_oc | a_forward_oc | A_reg_read_ack)
        & (b_zero_oc | b_saved_oc | b_forward_oc | B_reg_read_ack);
    assign issue_ready = ~valid_oc | launch_oc;

    // ------------------------------------------------------------------------
    // EX stage

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_ex <= 1'b0;
        end else if (~stall_ex) begin
            valid_ex <= valid_oc & launch_oc;
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall_ex) begin
            op_ex <= op_oc;
            a_pr_ex <= a_pr_oc;
            b_pr_ex <= b_pr_oc;
            dest_pr_ex <= dest_pr_oc;
            rob_ex <= rob_oc;
            a_data_ex <= a_data_oc;
            b_data_ex <= b_data_oc;
        end
    end

    // Multiplier stage 1 loads together with EX
    // MULHSU extends only A, MULHU neither
    assign mul.a33 = {(op_oc[1:0] != 2'b11) & a_data_oc[31], a_data_oc};
    assign mul.b33 = {~op_oc[1] & b_data_oc[31], b_data_oc};
    assign mul.ex_en = ~stall_ex;
    assign mul.wb_en = ~stall_wb;

    // Same divide operands as WB, so the divider already holds the answer
    assign hit_ex = valid_ex & op_ex[2] & valid_wb & op_wb[2]
        & (op_ex[0] == op_wb[0])
        & (a_pr_ex == a_pr_wb) & (b_pr_ex == b_pr_wb)
        & (a_data_ex == a_data_wb) & (b_data_ex == b_data_wb);
    assign hit_data_ex = op_ex[1] ? div.remainder : div.quotient;

    // ------------------------------------------------------------------------
    // WB stage

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_wb <= 1'b0;
            hit_wb <= 1'b0;
        end else if (~stall_wb) begin
            valid_wb <= valid_ex;
            hit_wb <= hit_ex;
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall_wb) begin
            op_wb <= op_ex;
            a_pr_wb <= a_pr_ex;
            b_pr_wb <= b_pr_ex;
            dest_pr_wb <= dest_pr_ex;
            rob_wb <= rob_ex;
            a_data_wb <= a_data_ex;
            b_data_wb <= b_data_ex;
            hit_data_wb <= hit_data_ex;
        end
    end

    // Divider restarts whenever WB is not an unfinished fresh divide
    assign div.clear = ~valid_wb | ~op_wb[2] | ~stall_wb | hit_wb;
    assign div.is_signed = ~op_wb[0];
    assign div.hold = stall_wb;
    assign div.dividend = a_data_wb;
    assign div.divisor = b_data_wb;

    always_comb begin
        if (~op_wb[2]) begin
            WB_data = (op_wb[1:0] == 2'b00) ? mul.product[31:0] : mul.product[63:32];
        end else if (hit_wb) begin
            WB_data = hit_data_wb;
        end else if (op_wb[1]) begin
            WB_data = div.remainder;
        end else begin
            WB_data = div.quotient;
        end
    end

    assign WB_valid = valid_wb & (~op_wb[2] | div.done | hit_wb);
    assign WB_PR = dest_pr_wb;
    assign WB_ROB_index = rob_wb;

endmodule

// ==== source/mdu_pkg.sv ====
/*
    Shared types for the multiply-divide unit: data words, op codes
    and the divider state encoding
*/

package mdu_pkg;

    // Data widths
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // Op code layout
    // Bit 2 picks the divider
    // Multiplies use bits 1:0 as the flavor
    // Divides use bit 1 for remainder and bit 0 for unsigned
    typedef logic [2:0] mdu_op_t;

    localparam mdu_op_t OP_MUL    = 3'b000;
    localparam mdu_op_t OP_MULH   = 3'b001;
    localparam mdu_op_t OP_MULHSU = 3'b010;
    localparam mdu_op_t OP_MULHU  = 3'b011;
    localparam mdu_op_t OP_DIV    = 3'b100;
    localparam mdu_op_t OP_DIVU   = 3'b101;
    localparam mdu_op_t OP_REM    = 3'b110;
    localparam mdu_op_t OP_REMU   = 3'b111;

    // Divider sequencing
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

endpackage

// ==== source/mdu_top.sv ====
/*
    Multiply-divide unit top level
    Pipeline, multiplier and divider joined through their interfaces
*/

`timescale 1ns/1ps

module mdu_top #(
    parameter int LOG_PR_COUNT    = 7,
    parameter int LOG_ROB_ENTRIES = 6
) (
    input  logic                        CLK,
    input  logic                        nRST,

    // Issue
    input  logic                        issue_valid,
    input  mdu_pkg::mdu_op_t            issue_op,
    input  logic                        issue_A_forward,
    input  logic                        issue_A_is_zero,
    input  logic [LOG_PR_COUNT-1:0]     issue_A_PR,
    input  logic                        issue_B_forward,
    input  logic                        issue_B_is_zero,
    input  logic [LOG_PR_COUNT-1:0]     issue_B_PR,
    input  logic [LOG_PR_COUNT-1:0]     issue_dest_PR,
    input  logic [LOG_ROB_ENTRIES-1:0]  issue_ROB_index,
    output logic                        issue_ready,

    // Operand data
    input  logic                        A_reg_read_ack,
    input  logic                        B_reg_read_ack,
    input  mdu_pkg::word_t              reg_read_A_data,
    input  mdu_pkg::word_t              reg_read_B_data,
    input  mdu_pkg::word_t              forward_A_data,
    input  mdu_pkg::word_t              forward_B_data,

    // Writeback
    output logic                        WB_valid,
    output mdu_pkg::word_t              WB_data,
    output logic [LOG_PR_COUNT-1:0]     WB_PR,
    output logic [LOG_ROB_ENTRIES-1:0]  WB_ROB_index,
    input  logic                        WB_ready
);

    mdu_mul_if mul ();
    mdu_div_if div ();

    mdu_pipeline #(
        .LOG_PR_COUNT(LOG_PR_COUNT),
        .LOG_ROB_ENTRIES(LOG_ROB_ENTRIES)
    ) pipeline (.*);

    mdu_multiplier multiplier (
        .CLK(CLK),
        .nRST(nRST),
        .mul(mul)
    );

    div32_nonrestoring divider (
        .CLK(CLK),
        .nRST(nRST),
        .div(div)
    );

endmodule

// ==== src.f ====
source/mdu_pkg.sv
source/mdu_mul_if.sv
source/mdu_div_if.sv
source/mdu_multiplier.sv
source/div32_nonrestoring.sv
source/mdu_pipeline.sv
source/mdu_top.sv
sim/mdu_tb.sv
